// File: files.f
hdl/mem_pkg.sv
hdl/reset_stretch.sv
hdl/tlb_lookup.sv
hdl/req_fifo.sv
hdl/axi_master.sv
hdl/mem_subsys_top.sv
test/axi_slave_model.sv
test/tb_mem_subsys.sv

// File: hdl/axi_master.sv
`timescale 1ns/10ps

module axi_master import mem_pkg::*; (
    input  logic        aclk,
    input  logic        rst_n_i,
    input  logic        req_valid_i,
    input  xlat_req_t   req_i,
    output logic        req_pop_o,
    output logic        rsp_valid_o,
    output mem_rsp_t    rsp_o,

    output addr_t       araddr_o,
    output logic        arvalid_o,
    input  logic        arready_i,
    input  word_t       rdata_i,
    input  logic [1:0]  rresp_i,
    input  logic        rvalid_i,
    output logic        rready_o,

    output addr_t       awaddr_o,
    output logic        awvalid_o,
    input  logic        awready_i,
    output word_t       wdata_o,
    output logic [3:0]  wstrb_o,
    output logic        wvalid_o,
    input  logic        wready_i,
    input  logic [1:0]  bresp_i,
    input  logic        bvalid_i,
    output logic        bready_o
);

    typedef enum logic [2:0] {
        IDLE,
        READ_ADDR,
        READ_DATA,
        WRITE_REQ,
        WRITE_RESP,
        DONE
    } state_e;

    state_e   state_q;
    logic     aw_pend_q;
    logic     w_pend_q;
    logic     aw_done;
    logic     w_done;
    mem_rsp_t rsp_q;

    // aw and w may complete in either order
    assign aw_done = !aw_pend_q || awready_i;
    assign w_done  = !w_pend_q || wready_i;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_valid_i) begin
                        if (req_i.exc != EXC_NONE) begin
                            state_q <= DONE;
                        end else if (req_i.write) begin
                            state_q   <= WRITE_REQ;
                            aw_pend_q <= 1'b1;
                            w_pend_q  <= 1'b1;
                        end else begin
                            state_q <= READ_ADDR;
                        end
                    end
                end
                READ_ADDR:  if (arready_i) state_q <= READ_DATA;
                READ_DATA:  if (rvalid_i) state_q <= DONE;
                WRITE_REQ: begin
                    if (awready_i) aw_pend_q <= 1'b0;
                    if (wready_i) w_pend_q <= 1'b0;
                    if (aw_done && w_done) state_q <= WRITE_RESP;
                end
                WRITE_RESP: if (bvalid_i) state_q <= DONE;
                DONE:       state_q <= IDLE;  // head popped here
                default:    state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state_q == IDLE && req_valid_i) begin
            rsp_q.rdata   <= '0;
            rsp_q.exc     <= req_i.exc;
            rsp_q.bus_err <= 1'b0;
        end else if (state_q == READ_DATA && rvalid_i) begin
            rsp_q.rdata   <= rdata_i;
            rsp_q.bus_err <= (rresp_i != 2'b00);
        end else if (state_q == WRITE_RESP && bvalid_i) begin
            rsp_q.bus_err <= (bresp_i != 2'b00);
        end
    end

    // fifo head stays put until popped, so the bus fields come from it
    assign araddr_o  = req_i.paddr;
    assign awaddr_o  = req_i.paddr;
    assign wdata_o   = req_i.wdata;
    assign wstrb_o   = req_i.byteen;
    assign arvalid_o = (state_q == READ_ADDR);
    assign rready_o  = (state_q == READ_DATA);
    assign awvalid_o = aw_pend_q;
    assign wvalid_o  = w_pend_q;
    assign bready_o  = (state_q == WRITE_RESP);

    assign req_pop_o   = (state_q == DONE);
    assign rsp_valid_o = (state_q == DONE);
    assign rsp_o       = rsp_q;

endmodule

// File: hdl/mem_pkg.sv
package mem_pkg;

    localparam int TLB_ENTRIES = 4;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [$clog2(TLB_ENTRIES)-1:0] tlb_idx_t;

    typedef enum logic [1:0] {
        EXC_NONE        = 2'd0,
        EXC_TLB_MISS    = 2'd1,
        EXC_TLB_INVALID = 2'd2,
        EXC_TLB_MOD     = 2'd3  // store to a clean page
    } exc_t;

    // core side request, by virtual address
    typedef struct packed {
        addr_t       vaddr;
        word_t       wdata;
        logic [3:0]  byteen;
        logic        write;
    } mem_req_t;

    // after translation, queued towards the bus
    typedef struct packed {
        addr_t       paddr;
        word_t       wdata;
        logic [3:0]  byteen;
        logic        write;
        exc_t        exc;     // nonzero items never reach the bus
    } xlat_req_t;

    typedef struct packed {
        word_t       rdata;
        exc_t        exc;
        logic        bus_err;
    } mem_rsp_t;

    typedef struct packed {
        logic [19:0] vpn;
        logic [19:0] pfn;
        logic        valid;
        logic        dirty;   // page writable
    } tlb_entry_t;

endpackage

// File: hdl/mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top import mem_pkg::*; #(
    parameter int RESET_HOLD = 16,
    parameter int FIFO_DEPTH = 4
) (
    input  logic        aclk,
    input  logic        aresetn,

    input  logic        req_valid_i,
    input  mem_req_t    req_i,
    output logic        req_ready_o,
    output logic        rsp_valid_o,
    output mem_rsp_t    rsp_o,

    input  logic        tlb_we_i,
    input  tlb_idx_t    tlb_idx_i,
    input  tlb_entry_t  tlb_entry_i,

    output addr_t       araddr_o,
    output logic        arvalid_o,
    input  logic        arready_i,
    input  word_t       rdata_i,
    input  logic [1:0]  rresp_i,
    input  logic        rvalid_i,
    output logic        rready_o,

    output addr_t       awaddr_o,
    output logic        awvalid_o,
    input  logic        awready_i,
    output word_t       wdata_o,
    output logic [3:0]  wstrb_o,
    output logic        wvalid_o,
    input  logic        wready_i,
    input  logic [1:0]  bresp_i,
    input  logic        bvalid_i,
    output logic        bready_o
);

    logic      rst_n;
    logic      xlat_valid;
    xlat_req_t xlat;
    logic      xlat_ready;
    logic      fifo_valid;
    xlat_req_t fifo_req;
    logic      fifo_pop;

    reset_stretch #(
        .RESET_HOLD(RESET_HOLD)
    ) u_reset_stretch (
        .aclk    (aclk),
        .aresetn (aresetn),
        .rst_n_o (rst_n)
    );

    tlb_lookup u_tlb_lookup (
        .aclk         (aclk),
        .rst_n_i      (rst_n),
        .tlb_we_i     (tlb_we_i),
        .tlb_idx_i    (tlb_idx_i),
        .tlb_entry_i  (tlb_entry_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .xlat_valid_o (xlat_valid),
        .xlat_o       (xlat),
        .xlat_ready_i (xlat_ready)
    );

    req_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_req_fifo (
        .aclk         (aclk),
        .rst_n_i      (rst_n),
        .push_valid_i (xlat_valid),
        .push_i       (xlat),
        .push_ready_o (xlat_ready),
        .pop_valid_o  (fifo_valid),
        .pop_o        (fifo_req),
        .pop_i        (fifo_pop)
    );

    axi_master u_axi_master (
        .aclk        (aclk),
        .rst_n_i     (rst_n),
        .req_valid_i (fifo_valid),
        .req_i       (fifo_req),
        .req_pop_o   (fifo_pop),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .araddr_o    (araddr_o),
        .arvalid_o   (arvalid_o),
        .arready_i   (arready_i),
        .rdata_i     (rdata_i),
        .rresp_i     (rresp_i),
        .rvalid_i    (rvalid_i),
        .rready_o    (rready_o),
        .awaddr_o    (awaddr_o),
        .awvalid_o   (awvalid_o),
        .awready_i   (awready_i),
        .wdata_o     (wdata_o),
        .wstrb_o     (wstrb_o),
        .wvalid_o    (wvalid_o),
        .wready_i    (wready_i),
        .bresp_i     (bresp_i),
        .bvalid_i    (bvalid_i),
        .bready_o    (bready_o)
    );

endmodule

// File: hdl/req_fifo.sv
`timescale 1ns/10ps

module req_fifo import mem_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      aclk,
    input  logic      rst_n_i,
    input  logic      push_valid_i,
    input  xlat_req_t push_i,
    output logic      push_ready_o,
    output logic      pop_valid_o,
    output xlat_req_t pop_o,
    input  logic      pop_i
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    xlat_req_t        mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign push_ready_o = (count_q != CNT_W'(FIFO_DEPTH));
    assign pop_valid_o  = (count_q != '0);
    assign pop_o        = mem_q[rd_ptr_q];

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_i && pop_valid_o;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                // wrap explicitly, depth need not be a power of two
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_i;
        end
    end

endmodule

// File: hdl/reset_stretch.sv
`timescale 1ns/10ps

module reset_stretch #(
    parameter int RESET_HOLD = 16
) (
    input  logic aclk,
    input  logic aresetn,
    output logic rst_n_o
);

    localparam int CNT_W = $clog2(RESET_HOLD + 1);

    logic [CNT_W-1:0] hold_cnt_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hold_cnt_q <= '0;
            rst_n_o    <= 1'b0;
        end else if (hold_cnt_q == CNT_W'(RESET_HOLD)) begin
            rst_n_o <= 1'b1;  // count saturates here
        end else begin
            hold_cnt_q <= hold_cnt_q + 1'b1;
        end
    end

endmodule

// File: hdl/tlb_lookup.sv
`timescale 1ns/10ps

module tlb_lookup import mem_pkg::*; (
    input  logic       aclk,
    input  logic       rst_n_i,
    input  logic       tlb_we_i,
    input  tlb_idx_t   tlb_idx_i,
    input  tlb_entry_t tlb_entry_i,
    input  logic       req_valid_i,
    input  mem_req_t   req_i,
    output logic       req_ready_o,
    output logic       xlat_valid_o,
    output xlat_req_t  xlat_o,
    input  logic       xlat_ready_i
);

    tlb_entry_t tlb_q [TLB_ENTRIES];
    tlb_entry_t hit_entry;
    logic       hit;
    logic       unmapped;
    logic       run_q;      // set one cycle after reset leaves
    logic       xlat_valid_q;
    xlat_req_t  xlat_q;
    xlat_req_t  xlat_d;
    logic       accept;

    // fully associative match on the page number
    always_comb begin
        hit       = 1'b0;
        hit_entry = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (tlb_q[i].vpn == req_i.vaddr[31:12]) begin
                hit       = 1'b1;
                hit_entry = tlb_q[i];
            end
        end
    end

    assign unmapped = (req_i.vaddr[31:30] == 2'b10); // kseg0 / kseg1

    always_comb begin
        xlat_d        = '0;
        xlat_d.wdata  = req_i.wdata;
        xlat_d.byteen = req_i.byteen;
        xlat_d.write  = req_i.write;
        xlat_d.paddr  = {hit_entry.pfn, req_i.vaddr[11:0]};
        if (unmapped) begin
            xlat_d.paddr = {3'b000, req_i.vaddr[28:0]};
            xlat_d.exc   = EXC_NONE;
        end else if (!hit) begin
            xlat_d.exc = EXC_TLB_MISS;
        end else if (!hit_entry.valid) begin
            xlat_d.exc = EXC_TLB_INVALID;
        end else if (req_i.write && !hit_entry.dirty) begin
            xlat_d.exc = EXC_TLB_MOD;
        end else begin
            xlat_d.exc = EXC_NONE;
        end
    end

    assign req_ready_o = run_q && (!xlat_valid_q || xlat_ready_i);
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                tlb_q[i] <= '0;
            end
        end else if (tlb_we_i) begin
            tlb_q[tlb_idx_i] <= tlb_entry_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            run_q        <= 1'b0;
            xlat_valid_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (accept) begin
                xlat_valid_q <= 1'b1;
            end else if (xlat_ready_i) begin
                xlat_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            xlat_q <= xlat_d;
        end
    end

    assign xlat_valid_o = xlat_valid_q;
    assign xlat_o       = xlat_q;

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_subsys -f files.f -o sim_mem_subsys
./obj_dir/sim_mem_subsys > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

// File: test/axi_slave_model.sv
`timescale 1ns/10ps

module axi_slave_model import mem_pkg::*; #(
    parameter int MEM_WORDS = 1024
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  addr_t       araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output word_t       rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rvalid_o,
    input  logic        rready_i,
    input  addr_t       awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  word_t       wdata_i,
    input  logic [3:0]  wstrb_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic [1:0]  bresp_o,
    output logic        bvalid_o,
    input  logic        bready_i,
    output int unsigned txn_count_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t       mem [MEM_WORDS];
    int unsigned rd_dly;
    int unsigned wr_dly;
    int unsigned rd_count;
    int unsigned wr_count;
    logic        rd_busy;
    logic        wr_busy;

    function automatic logic in_range(input addr_t a);
        return (a[31:2] < MEM_WORDS);
    endfunction

    initial begin
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        rdata_o   = '0;
        rresp_o   = 2'b00;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        bvalid_o  = 1'b0;
        bresp_o   = 2'b00;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h5a000000 ^ 32'(i * 4);  // byte address in the low bits
        end
    end

    always @(posedge aclk) begin
        if (!aresetn) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rdata_o   <= '0;
            rresp_o   <= 2'b00;
            rd_busy   <= 1'b0;
            rd_dly    <= 0;
            rd_count  <= 0;
        end else begin
            arready_o <= 1'b0;
            if (!rd_busy && arvalid_i) begin
                if (rd_dly == 0) begin
                    arready_o <= 1'b1;
                    rd_busy   <= 1'b1;
                    rd_dly    <= $urandom_range(3, 0);  // delay before rvalid
                    if (in_range(araddr_i)) begin
                        rdata_o <= mem[araddr_i[IDX_W+1:2]];
                        rresp_o <= 2'b00;
                    end else begin
                        rdata_o <= '0;
                        rresp_o <= 2'b10;  // SLVERR
                    end
                end else begin
                    rd_dly <= rd_dly - 1;
                end
            end else if (rd_busy && !rvalid_o && !arready_o) begin
                if (rd_dly == 0) begin
                    rvalid_o <= 1'b1;
                end else begin
                    rd_dly <= rd_dly - 1;
                end
            end else if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
                rd_busy  <= 1'b0;
                rd_dly   <= $urandom_range(3, 0);
                rd_count <= rd_count + 1;
            end
        end
    end

    always @(posedge aclk) begin
        if (!aresetn) begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            bresp_o   <= 2'b00;
            wr_busy   <= 1'b0;
            wr_dly    <= 0;
            wr_count  <= 0;
        end else begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            if (!wr_busy && awvalid_i && wvalid_i) begin
                if (wr_dly == 0) begin
                    awready_o <= 1'b1;  // aw and w taken in the same cycle
                    wready_o  <= 1'b1;
                    wr_busy   <= 1'b1;
                    wr_dly    <= $urandom_range(3, 0);
                    bresp_o   <= in_range(awaddr_i) ? 2'b00 : 2'b10;
                    if (in_range(awaddr_i)) begin
                        for (int b = 0; b < 4; b++) begin
                            if (wstrb_i[b]) begin
                                mem[awaddr_i[IDX_W+1:2]][8*b +: 8] <= wdata_i[8*b +: 8];
                            end
                        end
                    end
                end else begin
                    wr_dly <= wr_dly - 1;
                end
            end else if (wr_busy && !bvalid_o && !awready_o) begin
                if (wr_dly == 0) begin
                    bvalid_o <= 1'b1;
                end else begin
                    wr_dly <= wr_dly - 1;
                end
            end else if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
                wr_busy  <= 1'b0;
                wr_dly   <= $urandom_range(3, 0);
                wr_count <= wr_count + 1;
            end
        end
    end

    assign txn_count_o = rd_count + wr_count;

endmodule

// File: test/tb_mem_subsys.sv
`timescale 1ns/10ps

module tb_mem_subsys import mem_pkg::*; ();

    localparam int RESET_HOLD = 16;
    localparam int FIFO_DEPTH = 4;
    localparam int CLK_PERIOD = 10;
    localparam int MEM_WORDS  = 2048;

    typedef enum logic [1:0] {ST_TLB, ST_LOAD, ST_STORE} step_kind_e;

    typedef struct packed {
        step_kind_e kind;
        tlb_idx_t   idx;
        tlb_entry_t entry;
        addr_t      vaddr;
        word_t      wdata;
        logic [3:0] byteen;
        mem_rsp_t   exp;
    } step_t;

    logic        aclk;
    logic        aresetn;
    logic        req_valid_i;
    mem_req_t    req_i;
    logic        req_ready_o;
    logic        rsp_valid_o;
    mem_rsp_t    rsp_o;
    logic        tlb_we_i;
    tlb_idx_t    tlb_idx_i;
    tlb_entry_t  tlb_entry_i;
    addr_t       araddr;
    addr_t       awaddr;
    word_t       rdata;
    word_t       wdata;
    logic [3:0]  wstrb;
    logic [1:0]  rresp;
    logic [1:0]  bresp;
    logic        arvalid, arready, rvalid, rready;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    int unsigned txn_count;

    step_t       steps [$];
    string       step_names [$];
    int          exp_q [$];     // table indices of responses still due
    int unsigned bus_txns;
    int          checks;
    int          errors;

    mem_subsys_top #(
        .RESET_HOLD(RESET_HOLD),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) dut (
        .aclk(aclk), .aresetn(aresetn),
        .req_valid_i(req_valid_i), .req_i(req_i), .req_ready_o(req_ready_o),
        .rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o),
        .tlb_we_i(tlb_we_i), .tlb_idx_i(tlb_idx_i), .tlb_entry_i(tlb_entry_i),
        .araddr_o(araddr), .arvalid_o(arvalid), .arready_i(arready),
        .rdata_i(rdata), .rresp_i(rresp), .rvalid_i(rvalid), .rready_o(rready),
        .awaddr_o(awaddr), .awvalid_o(awvalid), .awready_i(awready),
        .wdata_o(wdata), .wstrb_o(wstrb), .wvalid_o(wvalid), .wready_i(wready),
        .bresp_i(bresp), .bvalid_i(bvalid), .bready_o(bready)
    );

    axi_slave_model #(
        .MEM_WORDS(MEM_WORDS)
    ) u_slave (
        .aclk(aclk), .aresetn(aresetn),
        .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid), .rready_i(rready),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
        .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
        .txn_count_o(txn_count)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    task automatic add_tlb(input string name, input tlb_idx_t idx, input logic [19:0] vpn,
                           input logic [19:0] pfn, input logic valid, input logic dirty);
        step_t s;
        s = '0;
        s.kind  = ST_TLB;
        s.idx   = idx;
        s.entry = '{vpn: vpn, pfn: pfn, valid: valid, dirty: dirty};
        steps.push_back(s);
        step_names.push_back(name);
    endtask

    task automatic add_access(input string name, input step_kind_e kind, input addr_t vaddr,
                              input word_t wd, input logic [3:0] be, input word_t exp_rdata,
                              input exc_t exc, input logic bus_err);
        step_t s;
        s = '0;
        s.kind   = kind;
        s.vaddr  = vaddr;
        s.wdata  = wd;
        s.byteen = be;
        s.exp    = '{rdata: exp_rdata, exc: exc, bus_err: bus_err};
        steps.push_back(s);
        step_names.push_back(name);
    endtask

    task automatic build_table();
        add_tlb("tlb data page", 2'd0, 20'h00400, 20'h00000, 1'b1, 1'b1);
        add_tlb("tlb clean page", 2'd1, 20'h00500, 20'h00001, 1'b1, 1'b0);
        add_tlb("tlb invalid page", 2'd2, 20'h00600, 20'h00001, 1'b0, 1'b1);
        // unmapped segments
        add_access("kseg0 store", ST_STORE, 32'h80000100, 32'h12345678, 4'hf, '0, EXC_NONE, 0);
        add_access("kseg0 load", ST_LOAD, 32'h80000100, '0, '0, 32'h12345678, EXC_NONE, 0);
        // mapped through entry 0, read back through the aliases
        add_access("mapped store", ST_STORE, 32'h00400080, 32'hcafef00d, 4'hf, '0, EXC_NONE, 0);
        add_access("kseg0 alias load", ST_LOAD, 32'h80000080, '0, '0, 32'hcafef00d, EXC_NONE, 0);
        add_access("partial store", ST_STORE, 32'h00400080, 32'h11223344, 4'h5, '0, EXC_NONE, 0);
        add_access("kseg1 alias load", ST_LOAD, 32'ha0000080, '0, '0, 32'hca22f044, EXC_NONE, 0);
        add_access("mapped load", ST_LOAD, 32'h00400080, '0, '0, 32'hca22f044, EXC_NONE, 0);
        // faults stay off the bus
        add_access("miss load", ST_LOAD, 32'h00700010, '0, '0, '0, EXC_TLB_MISS, 0);
        add_access("miss store", ST_STORE, 32'h00700010, 32'h1, 4'hf, '0, EXC_TLB_MISS, 0);
        add_access("invalid load", ST_LOAD, 32'h00600000, '0, '0, '0, EXC_TLB_INVALID, 0);
        add_access("clean store", ST_STORE, 32'h00500040, 32'h2, 4'hf, '0, EXC_TLB_MOD, 0);
        // second model page, still holding its fill word
        add_access("clean load", ST_LOAD, 32'h00500080, '0, '0, 32'h5a001080, EXC_NONE, 0);
        add_access("load past model", ST_LOAD, 32'h80002000, '0, '0, '0, EXC_NONE, 1);
        add_access("store past model", ST_STORE, 32'ha0004000, 32'h3, 4'hf, '0, EXC_NONE, 1);
        // mixed stream
        add_access("mix store a", ST_STORE, 32'h80000200, 32'ha5a50001, 4'hf, '0, EXC_NONE, 0);
        add_access("mix miss", ST_LOAD, 32'h00800000, '0, '0, '0, EXC_TLB_MISS, 0);
        add_access("mix store b", ST_STORE, 32'h00400204, 32'h5a5a0002, 4'hf, '0, EXC_NONE, 0);
        add_access("mix invalid", ST_STORE, 32'h00600008, 32'h4, 4'hf, '0, EXC_TLB_INVALID, 0);
        add_access("mix load a", ST_LOAD, 32'h80000200, '0, '0, 32'ha5a50001, EXC_NONE, 0);
        add_access("mix load b", ST_LOAD, 32'ha0000204, '0, '0, 32'h5a5a0002, EXC_NONE, 0);
        add_access("mix mod", ST_STORE, 32'h00500204, 32'h5, 4'hf, '0, EXC_TLB_MOD, 0);
        add_access("mix mapped b", ST_LOAD, 32'h00400204, '0, '0, 32'h5a5a0002, EXC_NONE, 0);
        add_access("mix byte store", ST_STORE, 32'h80000200, 32'h000000ff, 4'h1, '0, EXC_NONE, 0);
        add_access("mix byte load", ST_LOAD, 32'h80000200, '0, '0, 32'ha5a500ff, EXC_NONE, 0);
        add_tlb("tlb page made dirty", 2'd1, 20'h00500, 20'h00001, 1'b1, 1'b1);
        add_access("dirty store", ST_STORE, 32'h00500300, 32'h0badcafe, 4'hf, '0, EXC_NONE, 0);
        add_access("dirty load", ST_LOAD, 32'h80001300, '0, '0, 32'h0badcafe, EXC_NONE, 0);
    endtask

    // called 1 ns after a rising edge, returns at the same point
    task automatic apply_step(input int i);
        step_t    s;
        mem_req_t r;
        s = steps[i];
        if (s.kind == ST_TLB) begin
            tlb_we_i    = 1'b1;
            tlb_idx_i   = s.idx;
            tlb_entry_i = s.entry;
            @(posedge aclk);
            #1;
            tlb_we_i = 1'b0;
        end else begin
            r.vaddr  = s.vaddr;
            r.wdata  = s.wdata;
            r.byteen = s.byteen;
            r.write  = (s.kind == ST_STORE);
            exp_q.push_back(i);
            req_i       = r;
            req_valid_i = 1'b1;
            while (!req_ready_o) begin
                @(posedge aclk);
                #1;
            end
            @(posedge aclk);
            #1;
            req_valid_i = 1'b0;
        end
    endtask

    task automatic run_watchdog(input int limit_cycles);
        repeat (limit_cycles) @(posedge aclk);
        $display("watchdog expired after %0d cycles with responses missing", limit_cycles);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic check_model_word(input string name, input addr_t paddr, input word_t exp);
        word_t act;
        act = u_slave.mem[int'(paddr >> 2)];
        checks++;
        assert (act == exp) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // responses sampled mid-cycle
    always @(negedge aclk) begin
        int       idx;
        mem_rsp_t exp;
        if (rsp_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("a response arrived with no request outstanding");
            end else begin
                idx = exp_q.pop_front();
                exp = steps[idx].exp;
                checks++;
                assert (rsp_o == exp) else begin
                    errors++;
                    $display("FAILED %s: expected %h exc %0d err %b, actual %h exc %0d err %b",
                             step_names[idx], exp.rdata, exp.exc, exp.bus_err,
                             rsp_o.rdata, rsp_o.exc, rsp_o.bus_err);
                end
                if (exp.exc == EXC_NONE) bus_txns++;  // faults add none
                assert (txn_count == bus_txns) else begin
                    errors++;
                    $display("FAILED %s bus transactions: expected %0d, actual %0d",
                             step_names[idx], bus_txns, txn_count);
                end
            end
        end
    end

    initial begin
        void'($urandom(19));
        aresetn     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        tlb_we_i    = 1'b0;
        tlb_idx_i   = '0;
        tlb_entry_i = '0;
        bus_txns    = 0;
        checks      = 0;
        errors      = 0;
        build_table();
        fork
            run_watchdog(steps.size() * 50 + RESET_HOLD);
        join_none
        repeat (2) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        // reset stretch window
        repeat (RESET_HOLD) begin
            @(negedge aclk);
            checks++;
            assert (!req_ready_o && !rsp_valid_o && !arvalid && !awvalid && !wvalid
                    && !rready && !bready) else begin
                errors++;
                $display("a handshake output went high inside the reset hold window");
            end
        end
        while (!req_ready_o) @(negedge aclk);
        @(posedge aclk);
        #1;
        for (int i = 0; i < steps.size(); i++) begin
            apply_step(i);
        end
        while (exp_q.size() != 0) @(posedge aclk);
        repeat (4) @(posedge aclk);
        check_model_word("kseg0 store location", 32'h00000100, 32'h12345678);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
